// ==== muntjac_pkg.sv ====
// Shared definitions for the fetch and memory issue slice of the core
// Widths, boot address, fetch queue sizing, opcodes and the cache structs

package muntjac_pkg;

    // Datapath widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // First fetch address after reset
    localparam logic [63:0] BOOT_PC = 64'h8000_0000;

    // Fetch queue sizing
    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
    localparam int FQ_CNT_W = $clog2(FQ_DEPTH + 1);

    // Major opcodes handled by the memory issue unit
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Why a fetch was issued
    typedef enum logic [1:0] {
        IF_RESET = 2'd0,
        IF_NEXT  = 2'd1
    } if_reason_e;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        if_reason_e      reason;
    } icache_req_t;

    typedef struct packed {
        logic            valid;
        logic [ILEN-1:0] instr;
    } icache_resp_t;

    // One fetched instruction with the PC it came from
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } fetch_entry_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] value;
        mem_op_e         op;
        logic [1:0]      size;  // log2 of the access size in bytes
        logic            is_unsigned;
    } dcache_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] value;
    } dcache_resp_t;

endpackage

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

// Fetch unit
// Requests sequential instruction words from the instruction cache, one at a
// time, and only while the fetch queue has room for the returning word

module fetch_unit (
    input  logic                             clk_i,
    input  logic                             reset_i,

    // Instruction cache
    output muntjac_pkg::icache_req_t         icache_req_o,
    input  muntjac_pkg::icache_resp_t        icache_resp_i,

    // Fetch queue write side
    input  logic [muntjac_pkg::FQ_CNT_W-1:0] fq_count_i,
    output logic                             fq_push_o,
    output muntjac_pkg::fetch_entry_t        fq_entry_o
);

    import muntjac_pkg::*;

    logic [XLEN-1:0]   next_pc_q;
    logic              first_q;
    logic              active_q;
    logic              outstanding_q;
    logic [FQ_CNT_W:0] in_flight;
    logic              credit_ok;
    logic              issue;

    // Words already queued plus the one still inside the cache
    assign in_flight = {1'b0, fq_count_i} + {{FQ_CNT_W{1'b0}}, outstanding_q};
    assign credit_ok = in_flight < (FQ_CNT_W + 1)'(FQ_DEPTH);

    // Only one request in flight at a time
    assign issue = active_q && !outstanding_q && credit_ok;

    assign icache_req_o.valid  = issue;
    assign icache_req_o.pc     = next_pc_q;
    assign icache_req_o.reason = first_q ? IF_RESET : IF_NEXT;

    // next_pc_q still holds the requested PC while the response is pending
    assign fq_push_o        = icache_resp_i.valid;
    assign fq_entry_o.pc    = next_pc_q;
    assign fq_entry_o.instr = icache_resp_i.instr;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            next_pc_q     <= BOOT_PC;
            first_q       <= 1'b1;
            active_q      <= 1'b0;
            outstanding_q <= 1'b0;
        end else begin
            // Hold off the first request until one cycle after reset
            active_q <= 1'b1;

            if (issue) begin
                outstanding_q <= 1'b1;
                first_q       <= 1'b0;
            end

            // Advance to the next word once the current one has returned
            if (icache_resp_i.valid) begin
                outstanding_q <= 1'b0;
                next_pc_q     <= next_pc_q + XLEN'(4);
            end
        end
    end

endmodule

// ==== fetch_queue.sv ====
`timescale 1ns/1ps

// Fetch queue
// Small circular FIFO between fetch and issue, with an occupancy count that
// the fetch unit uses as credit

module fetch_queue (
    input  logic                             clk_i,
    input  logic                             reset_i,

    // Write side
    input  logic                             push_i,
    input  muntjac_pkg::fetch_entry_t        push_entry_i,

    // Read side
    output logic                             pop_valid_o,
    input  logic                             pop_ready_i,
    output muntjac_pkg::fetch_entry_t        pop_entry_o,

    output logic [muntjac_pkg::FQ_CNT_W-1:0] count_o
);

    import muntjac_pkg::*;

    fetch_entry_t        mem_q [FQ_DEPTH];
    logic [FQ_PTR_W-1:0] rd_ptr_q;
    logic [FQ_PTR_W-1:0] wr_ptr_q;
    logic [FQ_CNT_W-1:0] count_q;
    logic                empty;
    logic                full;
    logic                do_push;
    logic                do_pop;

    function automatic logic [FQ_PTR_W-1:0] ptr_next(input logic [FQ_PTR_W-1:0] ptr);
        if (ptr == FQ_PTR_W'(FQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + FQ_PTR_W'(1);
    endfunction

    assign empty = count_q == '0;
    assign full  = count_q == FQ_CNT_W'(FQ_DEPTH);

    assign pop_valid_o = !empty;
    assign pop_entry_o = mem_q[rd_ptr_q];
    assign count_o     = count_q;

    assign do_pop  = pop_ready_i && !empty;
    // When full a push only fits if the head leaves in the same cycle
    assign do_push = push_i && (!full || do_pop);

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end

            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + FQ_CNT_W'(1);
                2'b01:   count_q <= count_q - FQ_CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== mem_issue_unit.sv ====
`timescale 1ns/1ps

// Memory issue unit
// Turns loads and stores at the head of the fetch queue into data cache
// requests and retires every other instruction as soon as it arrives

module mem_issue_unit (
    input  logic                             clk_i,
    input  logic                             reset_i,

    // Fetch queue read side
    input  logic                             entry_valid_i,
    output logic                             entry_ready_o,
    input  muntjac_pkg::fetch_entry_t        entry_i,

    // Data cache
    output muntjac_pkg::dcache_req_t         dcache_req_o,
    input  logic                             dcache_req_ready_i,
    input  muntjac_pkg::dcache_resp_t        dcache_resp_i,

    output logic [muntjac_pkg::XLEN-1:0]     dbg_pc_o
);

    import muntjac_pkg::*;

    typedef enum logic {
        ST_ISSUE,
        ST_WAIT_LOAD
    } state_e;

    state_e          state_q;
    logic [XLEN-1:0] last_load_q;
    logic [XLEN-1:0] dbg_pc_q;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_load;
    logic            is_store;
    logic            is_mem;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic            req_valid;
    logic            req_fire;
    logic            load_done;
    logic            retire;

    // Decode of the instruction at the queue head
    assign opcode   = entry_i.instr[6:0];
    assign funct3   = entry_i.instr[14:12];
    assign is_load  = opcode == OPCODE_LOAD;
    assign is_store = opcode == OPCODE_STORE;
    assign is_mem   = is_load || is_store;

    // Base register is taken as x0 so the immediate is the whole address
    assign imm_i = {{(XLEN - 12){entry_i.instr[31]}}, entry_i.instr[31:20]};
    assign imm_s = {{(XLEN - 12){entry_i.instr[31]}}, entry_i.instr[31:25],
                    entry_i.instr[11:7]};

    // Head entry and last load value stay put until the request is taken
    assign req_valid = (state_q == ST_ISSUE) && entry_valid_i && is_mem;
    assign req_fire  = req_valid && dcache_req_ready_i;

    assign dcache_req_o.valid       = req_valid;
    assign dcache_req_o.address     = is_store ? imm_s : imm_i;
    assign dcache_req_o.value       = last_load_q;
    assign dcache_req_o.op          = is_store ? MEM_STORE : MEM_LOAD;
    assign dcache_req_o.size        = funct3[1:0];
    assign dcache_req_o.is_unsigned = funct3[2];

    // Load data either while waiting or in the very cycle of acceptance
    assign load_done = dcache_resp_i.valid &&
                       ((state_q == ST_WAIT_LOAD) || (req_fire && is_load));

    always_comb begin
        entry_ready_o = 1'b0;
        if (state_q == ST_ISSUE) begin
            if (!is_mem) begin
                entry_ready_o = 1'b1;
            end else if (is_store) begin
                entry_ready_o = dcache_req_ready_i;
            end else begin
                entry_ready_o = dcache_req_ready_i && dcache_resp_i.valid;
            end
        end else begin
            entry_ready_o = dcache_resp_i.valid;
        end
    end

    assign retire   = entry_valid_i && entry_ready_o;
    assign dbg_pc_o = dbg_pc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= ST_ISSUE;
            last_load_q <= '0;
            dbg_pc_q    <= '0;
        end else begin
            if (retire) begin
                dbg_pc_q <= entry_i.pc;
            end

            if (load_done) begin
                last_load_q <= dcache_resp_i.value;
            end

            case (state_q)
                ST_ISSUE: begin
                    if (req_fire && is_load && !dcache_resp_i.valid) begin
                        state_q <= ST_WAIT_LOAD;
                    end
                end
                ST_WAIT_LOAD: begin
                    if (dcache_resp_i.valid) begin
                        state_q <= ST_ISSUE;
                    end
                end
                default: state_q <= ST_ISSUE;
            endcase
        end
    end

endmodule

// ==== muntjac_core.sv ====
`timescale 1ns/1ps

// Core slice
// Fetch unit feeding the memory issue unit through the fetch queue

module muntjac_core (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Instruction cache
    output muntjac_pkg::icache_req_t     icache_req_o,
    input  muntjac_pkg::icache_resp_t    icache_resp_i,

    // Data cache
    output muntjac_pkg::dcache_req_t     dcache_req_o,
    input  logic                         dcache_req_ready_i,
    input  muntjac_pkg::dcache_resp_t    dcache_resp_i,

    output logic [muntjac_pkg::XLEN-1:0] dbg_pc_o
);

    import muntjac_pkg::*;

    logic [FQ_CNT_W-1:0] fq_count;
    logic                fq_push;
    fetch_entry_t        fq_push_entry;
    logic                fq_pop_valid;
    logic                fq_pop_ready;
    fetch_entry_t        fq_pop_entry;

    fetch_unit fetch_unit_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .icache_req_o  (icache_req_o),
        .icache_resp_i (icache_resp_i),
        .fq_count_i    (fq_count),
        .fq_push_o     (fq_push),
        .fq_entry_o    (fq_push_entry)
    );

    fetch_queue fetch_queue_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .push_i       (fq_push),
        .push_entry_i (fq_push_entry),
        .pop_valid_o  (fq_pop_valid),
        .pop_ready_i  (fq_pop_ready),
        .pop_entry_o  (fq_pop_entry),
        .count_o      (fq_count)
    );

    mem_issue_unit mem_issue_unit_inst (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .entry_valid_i      (fq_pop_valid),
        .entry_ready_o      (fq_pop_ready),
        .entry_i            (fq_pop_entry),
        .dcache_req_o       (dcache_req_o),
        .dcache_req_ready_i (dcache_req_ready_i),
        .dcache_resp_i      (dcache_resp_i),
        .dbg_pc_o           (dbg_pc_o)
    );

endmodule

// ==== pipeline_wrapper.sv ====
`timescale 1ns/1ps

// Top level for Verilator
// Flattens the core's cache structs into plain ports so a C++ or
// SystemVerilog harness can drive them directly

module pipeline_wrapper (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Instruction cache
    output logic                         icache_req_valid_o,
    output logic [muntjac_pkg::XLEN-1:0] icache_req_pc_o,
    output muntjac_pkg::if_reason_e      icache_req_reason_o,
    input  logic                         icache_resp_valid_i,
    input  logic [muntjac_pkg::ILEN-1:0] icache_resp_instr_i,

    // Data cache
    output logic                         dcache_req_valid_o,
    input  logic                         dcache_req_ready_i,
    output logic [muntjac_pkg::XLEN-1:0] dcache_req_address_o,
    output logic [muntjac_pkg::XLEN-1:0] dcache_req_value_o,
    output muntjac_pkg::mem_op_e         dcache_req_op_o,
    output logic [1:0]                   dcache_req_size_o,
    output logic                         dcache_req_unsigned_o,
    input  logic                         dcache_resp_valid_i,
    input  logic [muntjac_pkg::XLEN-1:0] dcache_resp_value_i,

    // Debug
    output logic [muntjac_pkg::XLEN-1:0] dbg_pc_o
);

    import muntjac_pkg::*;

    icache_req_t  icache_req;
    icache_resp_t icache_resp;
    dcache_req_t  dcache_req;
    dcache_resp_t dcache_resp;

    muntjac_core muntjac_core_inst (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .icache_req_o       (icache_req),
        .icache_resp_i      (icache_resp),
        .dcache_req_o       (dcache_req),
        .dcache_req_ready_i (dcache_req_ready_i),
        .dcache_resp_i      (dcache_resp),
        .dbg_pc_o           (dbg_pc_o)
    );

    // Instruction cache
    assign icache_req_valid_o  = icache_req.valid;
    assign icache_req_pc_o     = icache_req.pc;
    assign icache_req_reason_o = icache_req.reason;
    assign icache_resp.valid   = icache_resp_valid_i;
    assign icache_resp.instr   = icache_resp_instr_i;

    // Data cache
    assign dcache_req_valid_o    = dcache_req.valid;
    assign dcache_req_address_o  = dcache_req.address;
    assign dcache_req_value_o    = dcache_req.value;
    assign dcache_req_op_o       = dcache_req.op;
    assign dcache_req_size_o     = dcache_req.size;
    assign dcache_req_unsigned_o = dcache_req.is_unsigned;
    assign dcache_resp.valid     = dcache_resp_valid_i;
    assign dcache_resp.value     = dcache_resp_value_i;

endmodule

// ==== tb_pipeline_wrapper.sv ====
`timescale 1ns/1ps

// Testbench for the pipeline wrapper
// Runs a short load and store program against instruction and data cache models

module tb_pipeline_wrapper;

    import muntjac_pkg::*;

    localparam int N_ROWS  = 12;
    localparam int TIMEOUT = 200;

    // One program row with what the data cache should see for it
    typedef struct packed {
        logic [ILEN-1:0] instr;
        logic            is_mem;
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [1:0]      size;
        logic            uns;
        logic [XLEN-1:0] data;
    } row_t;

    logic            clk;
    logic            reset_i;
    logic            icache_req_valid;
    logic [XLEN-1:0] icache_req_pc;
    if_reason_e      icache_req_reason;
    logic            icache_resp_valid;
    logic [ILEN-1:0] icache_resp_instr;
    logic            dcache_req_valid;
    logic            dcache_req_ready;
    logic [XLEN-1:0] dcache_req_address;
    logic [XLEN-1:0] dcache_req_value;
    mem_op_e         dcache_req_op;
    logic [1:0]      dcache_req_size;
    logic            dcache_req_unsigned;
    logic            dcache_resp_valid;
    logic [XLEN-1:0] dcache_resp_value;
    logic [XLEN-1:0] dbg_pc;

    row_t            rows [N_ROWS];
    int              fetch_cnt   = 0;
    int              retire_cnt  = 0;
    int              mem_row_idx = 0;
    int              stall_left  = 0;
    int              ic_wait     = 0;
    int              dc_wait     = 0;
    logic [XLEN-1:0] ic_pc       = '0;
    logic [XLEN-1:0] dc_data     = '0;
    logic [XLEN-1:0] last_dbg_pc = '0;
    logic            dc_held     = 1'b0;
    logic [XLEN-1:0] held_addr   = '0;
    logic [XLEN-1:0] held_value  = '0;
    logic [3:0]      held_ctrl   = '0;

    pipeline_wrapper pipeline_wrapper_inst (
        .clk_i                 (clk),
        .reset_i               (reset_i),
        .icache_req_valid_o    (icache_req_valid),
        .icache_req_pc_o       (icache_req_pc),
        .icache_req_reason_o   (icache_req_reason),
        .icache_resp_valid_i   (icache_resp_valid),
        .icache_resp_instr_i   (icache_resp_instr),
        .dcache_req_valid_o    (dcache_req_valid),
        .dcache_req_ready_i    (dcache_req_ready),
        .dcache_req_address_o  (dcache_req_address),
        .dcache_req_value_o    (dcache_req_value),
        .dcache_req_op_o       (dcache_req_op),
        .dcache_req_size_o     (dcache_req_size),
        .dcache_req_unsigned_o (dcache_req_unsigned),
        .dcache_resp_valid_i   (dcache_resp_valid),
        .dcache_resp_value_i   (dcache_resp_value),
        .dbg_pc_o              (dbg_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic end_failed();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string sig, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] got);
        $display("[ERROR] %0t %s expected %0h got %0h", $time, sig, exp, got);
        end_failed();
    endtask

    task automatic fail_with(input string msg);
        $display("%0t %s", $time, msg);
        end_failed();
    endtask

    function automatic row_t other_row(input logic [ILEN-1:0] instr);
        row_t r;
        r       = '0;
        r.instr = instr;
        return r;
    endfunction

    // Base register is x0, so the address is the sign-extended immediate
    function automatic row_t mem_row(input mem_op_e op, input logic [11:0] imm,
                                     input logic [2:0] f3, input logic [XLEN-1:0] data);
        row_t r;
        r        = '0;
        r.is_mem = 1'b1;
        r.op     = op;
        r.addr   = {{(XLEN - 12){imm[11]}}, imm};
        r.size   = f3[1:0];
        r.uns    = f3[2];
        r.data   = data;
        if (op == MEM_LOAD) begin
            r.instr = {imm, 5'd0, f3, 5'd5, OPCODE_LOAD};
        end else begin
            r.instr = {imm[11:5], 5'd6, 5'd0, f3, imm[4:0], OPCODE_STORE};
        end
        return r;
    endfunction

    // A store writes whatever the latest earlier load returned
    function automatic logic [XLEN-1:0] store_value(input int idx);
        for (int j = idx - 1; j >= 0; j--) begin
            if (rows[j].is_mem && rows[j].op == MEM_LOAD) begin
                return rows[j].data;
            end
        end
        return '0;
    endfunction

    task automatic track_retire();
        if (dbg_pc != last_dbg_pc) begin
            assert (dbg_pc == BOOT_PC + XLEN'(4 * retire_cnt)) else
                mismatch("dbg_pc_o", BOOT_PC + XLEN'(4 * retire_cnt), dbg_pc);
            last_dbg_pc = dbg_pc;
            retire_cnt++;
        end
    endtask

    task automatic icache_model();
        int         idx;
        if_reason_e exp_reason;
        exp_reason = (fetch_cnt == 0) ? IF_RESET : IF_NEXT;
        if (icache_req_valid) begin
            assert (ic_wait == 0) else fail_with("icache request while another is outstanding");
            assert (icache_req_pc == BOOT_PC + XLEN'(4 * fetch_cnt)) else
                mismatch("icache_req_pc_o", BOOT_PC + XLEN'(4 * fetch_cnt), icache_req_pc);
            assert (icache_req_reason == exp_reason) else
                mismatch("icache_req_reason_o", XLEN'(exp_reason), XLEN'(icache_req_reason));
        end
        icache_resp_valid = 1'b0;
        if (ic_wait > 0) begin
            ic_wait--;
            if (ic_wait == 0) begin
                idx = int'((ic_pc - BOOT_PC) >> 2);
                icache_resp_valid = 1'b1;
                // Past the end of the program the cache returns no-ops
                icache_resp_instr = (idx < N_ROWS) ? rows[idx].instr : 32'h0000_0013;
            end
        end
        if (icache_req_valid) begin
            ic_pc   = icache_req_pc;
            ic_wait = $urandom_range(1, 3);
            fetch_cnt++;
        end
    endtask

    task automatic check_dcache_request();
        row_t r;
        int   delay;
        while (mem_row_idx < N_ROWS && !rows[mem_row_idx].is_mem) begin
            mem_row_idx++;
        end
        assert (mem_row_idx < N_ROWS) else fail_with("dcache request with no memory row left");
        r = rows[mem_row_idx];
        assert (dcache_req_op == r.op) else
            mismatch("dcache_req_op_o", XLEN'(r.op), XLEN'(dcache_req_op));
        assert (dcache_req_address == r.addr) else
            mismatch("dcache_req_address_o", r.addr, dcache_req_address);
        assert (dcache_req_size == r.size) else
            mismatch("dcache_req_size_o", XLEN'(r.size), XLEN'(dcache_req_size));
        assert (dcache_req_unsigned == r.uns) else
            mismatch("dcache_req_unsigned_o", XLEN'(r.uns), XLEN'(dcache_req_unsigned));
        if (r.op == MEM_STORE) begin
            assert (dcache_req_value == store_value(mem_row_idx)) else
                mismatch("dcache_req_value_o", store_value(mem_row_idx), dcache_req_value);
        end else begin
            delay   = $urandom_range(0, 2);
            dc_data = r.data;
            if (delay == 0) begin
                dcache_resp_valid = 1'b1;
                dcache_resp_value = dc_data;
            end else begin
                dc_wait = delay;
            end
        end
        mem_row_idx++;
    endtask

    task automatic dcache_model();
        // A request not taken last cycle must be presented unchanged
        if (dc_held) begin
            assert (dcache_req_valid) else fail_with("dcache request withdrawn before acceptance");
            assert (dcache_req_address == held_addr) else
                mismatch("dcache_req_address_o", held_addr, dcache_req_address);
            assert (dcache_req_value == held_value) else
                mismatch("dcache_req_value_o", held_value, dcache_req_value);
            assert ({dcache_req_op, dcache_req_size, dcache_req_unsigned} == held_ctrl) else
                mismatch("dcache_req_op_o/size_o/unsigned_o", XLEN'(held_ctrl),
                         XLEN'({dcache_req_op, dcache_req_size, dcache_req_unsigned}));
        end
        dcache_resp_valid = 1'b0;
        if (dc_wait > 0) begin
            dc_wait--;
            if (dc_wait == 0) begin
                dcache_resp_valid = 1'b1;
                dcache_resp_value = dc_data;
            end
        end
        if (stall_left > 0) begin
            dcache_req_ready = 1'b0;
            stall_left--;
        end else begin
            dcache_req_ready = ($urandom_range(0, 3) != 0);
        end
        dc_held    = dcache_req_valid && !dcache_req_ready;
        held_addr  = dcache_req_address;
        held_value = dcache_req_value;
        held_ctrl  = {dcache_req_op, dcache_req_size, dcache_req_unsigned};
        if (dcache_req_valid && dcache_req_ready) begin
            check_dcache_request();
        end
    endtask

    // Outputs are sampled at the falling edge, then new inputs go out
    task automatic step();
        @(negedge clk);
        track_retire();
        icache_model();
        dcache_model();
        assert (fetch_cnt - retire_cnt <= FQ_DEPTH + 1) else
            fail_with("more instructions in flight than the fetch queue allows");
    endtask

    initial begin
        int waited;
        void'($urandom(32'h7381_be98));
        reset_i           = 1'b1;
        icache_resp_valid = 1'b0;
        icache_resp_instr = '0;
        dcache_req_ready  = 1'b0;
        dcache_resp_valid = 1'b0;
        dcache_resp_value = '0;

        rows[0]  = other_row(32'h0020_81b3);
        rows[1]  = mem_row(MEM_STORE, 12'h010, 3'b011, '0);
        rows[2]  = mem_row(MEM_LOAD,  12'h100, 3'b011, 64'h1122_3344_5566_7788);
        rows[3]  = mem_row(MEM_LOAD,  12'hff8, 3'b010, 64'hffff_ffff_8000_0001);
        rows[4]  = other_row(32'h0000_0013);
        rows[5]  = mem_row(MEM_STORE, 12'h024, 3'b010, '0);
        rows[6]  = mem_row(MEM_LOAD,  12'h7ff, 3'b100, 64'h0000_0000_0000_00a5);
        rows[7]  = other_row(32'h4020_8233);
        rows[8]  = mem_row(MEM_STORE, 12'h800, 3'b000, '0);
        rows[9]  = mem_row(MEM_LOAD,  12'h00a, 3'b101, 64'h0000_0000_0000_beef);
        rows[10] = mem_row(MEM_STORE, 12'hffe, 3'b001, '0);
        rows[11] = other_row(32'h0010_0093);

        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!icache_req_valid) else mismatch("icache_req_valid_o", '0, XLEN'(icache_req_valid));
        assert (!dcache_req_valid) else mismatch("dcache_req_valid_o", '0, XLEN'(dcache_req_valid));
        assert (dbg_pc == '0) else mismatch("dbg_pc_o", '0, dbg_pc);
        reset_i = 1'b0;

        for (int i = 0; i < N_ROWS; i++) begin
            // Hold the data cache off long enough for the queue to fill
            if (i == 3) begin
                stall_left = 30;
            end
            waited = 0;
            while (retire_cnt <= i) begin
                assert (waited < TIMEOUT) else
                    fail_with($sformatf("timed out waiting for row %0d to retire", i));
                step();
                waited++;
            end
        end

        for (int j = mem_row_idx; j < N_ROWS; j++) begin
            assert (!rows[j].is_mem) else
                fail_with($sformatf("row %0d retired without a dcache request", j));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
muntjac_pkg.sv
fetch_unit.sv
fetch_queue.sv
mem_issue_unit.sv
muntjac_core.sv
pipeline_wrapper.sv
tb_pipeline_wrapper.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_pipeline_wrapper -f sources.f -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
